/* common/gpu_types_pkg.sv */
`default_nettype none

package gpu_types_pkg;

    // Machine geometry of the execute stage
    localparam int XLEN       = 32;
    localparam int THREAD_CNT = 8;
    localparam int NUM_LANES  = 4;
    localparam int WARP_CNT   = 8;

    // A warp is split into PID_CNT packets of NUM_LANES threads each
    localparam int PID_CNT = THREAD_CNT / NUM_LANES;
    localparam int PID_W   = (PID_CNT > 1) ? $clog2(PID_CNT) : 1;

    localparam int WARP_W  = $clog2(WARP_CNT);
    localparam int UUID_W  = 8;
    localparam int NR_BITS = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [WARP_W-1:0]     wid_t;
    typedef logic [UUID_W-1:0]     uuid_t;
    typedef logic [NR_BITS-1:0]    reg_t;
    typedef logic [PID_W-1:0]      pid_t;
    typedef logic [NUM_LANES-1:0]  lane_mask_t;
    typedef logic [THREAD_CNT-1:0] thread_mask_t;

    // Integer operations of the lane ALU
    // OP_SLL shifts by the low 5 bits of operand b
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5
    } alu_op_t;

endpackage

`default_nettype wire

/* common/commit_pkg.sv */
`default_nettype none

package commit_pkg;

    // One warp instruction as it arrives on the issue port
    typedef struct packed {
        gpu_types_pkg::uuid_t                                 uuid;
        gpu_types_pkg::wid_t                                  wid;
        gpu_types_pkg::thread_mask_t                          tmask;
        gpu_types_pkg::alu_op_t                               op;
        gpu_types_pkg::reg_t                                  rd;
        logic                                                 wb;
        gpu_types_pkg::word_t [gpu_types_pkg::THREAD_CNT-1:0] a;
        gpu_types_pkg::word_t [gpu_types_pkg::THREAD_CNT-1:0] b;
    } issue_req_t;

    // One NUM_LANES-wide slice of a warp on its way into the lane ALU
    typedef struct packed {
        gpu_types_pkg::uuid_t                                uuid;
        gpu_types_pkg::wid_t                                 wid;
        gpu_types_pkg::lane_mask_t                           tmask;
        gpu_types_pkg::alu_op_t                              op;
        gpu_types_pkg::reg_t                                 rd;
        logic                                                wb;
        gpu_types_pkg::pid_t                                 pid;
        logic                                                sop;
        logic                                                eop;
        gpu_types_pkg::word_t [gpu_types_pkg::NUM_LANES-1:0] a;
        gpu_types_pkg::word_t [gpu_types_pkg::NUM_LANES-1:0] b;
    } lane_req_t;

    // Lane ALU output where the results take the place of the operands
    typedef struct packed {
        gpu_types_pkg::uuid_t                                uuid;
        gpu_types_pkg::wid_t                                 wid;
        gpu_types_pkg::lane_mask_t                           tmask;
        gpu_types_pkg::alu_op_t                              op;
        gpu_types_pkg::reg_t                                 rd;
        logic                                                wb;
        gpu_types_pkg::pid_t                                 pid;
        logic                                                sop;
        logic                                                eop;
        gpu_types_pkg::word_t [gpu_types_pkg::NUM_LANES-1:0] data;
    } lane_commit_t;

    // Commit packet with lanes placed back at their thread positions
    typedef struct packed {
        gpu_types_pkg::uuid_t                                 uuid;
        gpu_types_pkg::wid_t                                  wid;
        gpu_types_pkg::thread_mask_t                          tmask;
        gpu_types_pkg::reg_t                                  rd;
        logic                                                 wb;
        gpu_types_pkg::pid_t                                  pid;
        logic                                                 sop;
        logic                                                 eop;
        gpu_types_pkg::word_t [gpu_types_pkg::THREAD_CNT-1:0] data;
    } commit_t;

endpackage

`default_nettype wire

/* execute/lane_splitter.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_splitter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  commit_pkg::issue_req_t in,
    output logic                   in_ready,
    output logic                   out_valid,
    output commit_pkg::lane_req_t  out,
    input  logic                   out_ready
);

    localparam int LANES = gpu_types_pkg::NUM_LANES;
    localparam gpu_types_pkg::pid_t LAST_PID = gpu_types_pkg::pid_t'(gpu_types_pkg::PID_CNT - 1);

    commit_pkg::issue_req_t req_q;
    gpu_types_pkg::pid_t    pid_q;
    logic                   busy_q;

    // One warp is held at a time and a new one is taken once the last packet left
    assign in_ready  = !busy_q;
    assign out_valid = busy_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            pid_q  <= '0;
        end else if (in_valid && in_ready) begin
            busy_q <= 1'b1;
            pid_q  <= '0;
        end else if (out_valid && out_ready) begin
            if (pid_q == LAST_PID) begin
                busy_q <= 1'b0;
            end else begin
                pid_q <= pid_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            req_q <= in;
        end
    end

    // Slice the current packet out of the held warp
    always_comb begin
        out.uuid = req_q.uuid;
        out.wid  = req_q.wid;
        out.op   = req_q.op;
        out.rd   = req_q.rd;
        out.wb   = req_q.wb;
        out.pid  = pid_q;
        out.sop  = (pid_q == '0);
        out.eop  = (pid_q == LAST_PID);
        for (int l = 0; l < LANES; l++) begin
            out.tmask[l] = req_q.tmask[pid_q * LANES + l];
            out.a[l]     = req_q.a[pid_q * LANES + l];
            out.b[l]     = req_q.b[pid_q * LANES + l];
        end
    end

endmodule

`default_nettype wire

/* execute/lane_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module lane_alu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  commit_pkg::lane_req_t    in,
    output logic                     in_ready,
    output logic                     out_valid,
    output commit_pkg::lane_commit_t out,
    input  logic                     out_ready
);

    commit_pkg::lane_commit_t next;

    function automatic gpu_types_pkg::word_t alu_calc(
        input gpu_types_pkg::alu_op_t op,
        input gpu_types_pkg::word_t   a,
        input gpu_types_pkg::word_t   b
    );
        case (op)
            gpu_types_pkg::OP_ADD: return a + b;
            gpu_types_pkg::OP_SUB: return a - b;
            gpu_types_pkg::OP_AND: return a & b;
            gpu_types_pkg::OP_OR:  return a | b;
            gpu_types_pkg::OP_XOR: return a ^ b;
            gpu_types_pkg::OP_SLL: return a << b[4:0];
            default:               return '0;
        endcase
    endfunction

    // The stage advances when it is empty or its result is being taken
    assign in_ready = !out_valid || out_ready;

    always_comb begin
        next.uuid  = in.uuid;
        next.wid   = in.wid;
        next.tmask = in.tmask;
        next.op    = in.op;
        next.rd    = in.rd;
        next.wb    = in.wb;
        next.pid   = in.pid;
        next.sop   = in.sop;
        next.eop   = in.eop;
        // Inactive lanes produce zero
        for (int l = 0; l < gpu_types_pkg::NUM_LANES; l++) begin
            next.data[l] = in.tmask[l] ? alu_calc(in.op, in.a[l], in.b[l]) : '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= next;
        end
    end

endmodule

`default_nettype wire

/* source/issue_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

module issue_dispatch #(
    parameter int BLOCK_SIZE = 2
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   issue_valid,
    input  commit_pkg::issue_req_t                 issue,
    output logic                                   issue_ready,
    output logic [BLOCK_SIZE-1:0]                  lane_valid,
    output commit_pkg::lane_req_t [BLOCK_SIZE-1:0] lane,
    input  logic [BLOCK_SIZE-1:0]                  lane_ready
);

    localparam int BLOCK_W = (BLOCK_SIZE > 1) ? $clog2(BLOCK_SIZE) : 1;

    logic [BLOCK_W-1:0]    sel;
    logic [BLOCK_SIZE-1:0] split_valid;
    logic [BLOCK_SIZE-1:0] split_ready;

    // Warps are spread over the blocks by the low bits of their id
    assign sel = BLOCK_W'(issue.wid % BLOCK_SIZE);

    // Only the selected block sees the request, and only its ready counts
    assign issue_ready = split_ready[sel];

    for (genvar b = 0; b < BLOCK_SIZE; b++) begin : g_block
        assign split_valid[b] = issue_valid && (sel == BLOCK_W'(b));

        lane_splitter splitter (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (split_valid[b]),
            .in        (issue),
            .in_ready  (split_ready[b]),
            .out_valid (lane_valid[b]),
            .out       (lane[b]),
            .out_ready (lane_ready[b])
        );
    end

endmodule

`default_nettype wire

/* gather/elastic_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module elastic_buffer #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  logic [DATA_W-1:0] in_data,
    output logic              in_ready,
    output logic              out_valid,
    output logic [DATA_W-1:0] out_data,
    input  logic              out_ready
);

    logic [DATA_W-1:0] main_q;
    logic [DATA_W-1:0] spill_q;
    logic              main_valid_q;
    logic              spill_valid_q;
    logic              main_free;
    logic              main_load;
    logic              spill_load;

    // The spill register catches the word that arrives while the output stalls
    assign in_ready  = !spill_valid_q;
    assign out_valid = main_valid_q;
    assign out_data  = main_q;

    assign main_free  = !main_valid_q || out_ready;
    assign main_load  = main_free && (spill_valid_q || in_valid);
    assign spill_load = in_valid && in_ready && !main_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_valid_q  <= 1'b0;
            spill_valid_q <= 1'b0;
        end else if (main_free) begin
            main_valid_q  <= spill_valid_q || in_valid;
            spill_valid_q <= 1'b0;
        end else if (spill_load) begin
            spill_valid_q <= 1'b1;
        end
    end

    // A waiting spill entry always goes out before new input
    always_ff @(posedge clk) begin
        if (main_load) begin
            main_q <= spill_valid_q ? spill_q : in_data;
        end
        if (spill_load) begin
            spill_q <= in_data;
        end
    end

endmodule

`default_nettype wire

/* gather/gather_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module gather_unit #(
    parameter int BLOCK_SIZE = 2,
    parameter int ISSUE_CNT  = 4
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic [BLOCK_SIZE-1:0]                     in_valid,
    input  commit_pkg::lane_commit_t [BLOCK_SIZE-1:0] in,
    output logic [BLOCK_SIZE-1:0]                     in_ready,
    output logic [ISSUE_CNT-1:0]                      commit_valid,
    output commit_pkg::commit_t [ISSUE_CNT-1:0]       commit,
    input  logic [ISSUE_CNT-1:0]                      commit_ready
);

    localparam int BLOCK_W = (BLOCK_SIZE > 1) ? $clog2(BLOCK_SIZE) : 1;
    localparam int ISSUE_W = (ISSUE_CNT > 1) ? $clog2(ISSUE_CNT) : 1;
    localparam int LANES   = gpu_types_pkg::NUM_LANES;
    localparam int DATA_W  = $bits(commit_pkg::lane_commit_t);

    logic [BLOCK_SIZE-1:0][ISSUE_W-1:0]        in_slot;
    logic [ISSUE_CNT-1:0]                      slot_valid;
    commit_pkg::lane_commit_t [ISSUE_CNT-1:0]  slot_data;
    logic [ISSUE_CNT-1:0]                      slot_ready;
    commit_pkg::lane_commit_t [ISSUE_CNT-1:0]  buf_data;

    // Block b only ever carries warps whose slot has b in its low bits
    for (genvar b = 0; b < BLOCK_SIZE; b++) begin : g_slot
        if (ISSUE_CNT == 1) begin : g_one
            assign in_slot[b] = '0;
        end else if (BLOCK_SIZE == ISSUE_CNT) begin : g_direct
            assign in_slot[b] = ISSUE_W'(b);
        end else if (BLOCK_SIZE == 1) begin : g_wid
            assign in_slot[b] = in[b].wid[ISSUE_W-1:0];
        end else begin : g_mixed
            assign in_slot[b] = {in[b].wid[ISSUE_W-1:BLOCK_W], BLOCK_W'(b)};
        end
        assign in_ready[b] = slot_ready[in_slot[b]];
    end

    // Slots never collide, so plain steering is enough
    always_comb begin
        slot_valid = '0;
        slot_data  = '0;
        for (int b = 0; b < BLOCK_SIZE; b++) begin
            slot_valid[in_slot[b]] = in_valid[b];
            slot_data[in_slot[b]]  = in[b];
        end
    end

    for (genvar s = 0; s < ISSUE_CNT; s++) begin : g_port
        commit_pkg::commit_t scat;

        elastic_buffer #(
            .DATA_W (DATA_W)
        ) out_buf (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (slot_valid[s]),
            .in_data   (slot_data[s]),
            .in_ready  (slot_ready[s]),
            .out_valid (commit_valid[s]),
            .out_data  (buf_data[s]),
            .out_ready (commit_ready[s])
        );

        // Put each lane back at thread pid*LANES + lane and leave all other threads at zero
        always_comb begin
            scat.uuid  = buf_data[s].uuid;
            scat.wid   = buf_data[s].wid;
            scat.rd    = buf_data[s].rd;
            scat.wb    = buf_data[s].wb;
            scat.pid   = buf_data[s].pid;
            scat.sop   = buf_data[s].sop;
            scat.eop   = buf_data[s].eop;
            scat.tmask = '0;
            scat.data  = '0;
            for (int l = 0; l < LANES; l++) begin
                scat.tmask[buf_data[s].pid * LANES + l] = buf_data[s].tmask[l];
                scat.data[buf_data[s].pid * LANES + l]  = buf_data[s].data[l];
            end
        end

        assign commit[s] = scat;
    end

endmodule

`default_nettype wire

/* source/commit_top.sv */
`timescale 1ns/100ps
`default_nettype none

module commit_top #(
    parameter int BLOCK_SIZE = 2,
    parameter int ISSUE_CNT  = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                issue_valid,
    input  commit_pkg::issue_req_t              issue,
    output logic                                issue_ready,
    output logic [ISSUE_CNT-1:0]                commit_valid,
    output commit_pkg::commit_t [ISSUE_CNT-1:0] commit,
    input  logic [ISSUE_CNT-1:0]                commit_ready
);

    logic [BLOCK_SIZE-1:0]                     lane_valid;
    commit_pkg::lane_req_t [BLOCK_SIZE-1:0]    lane;
    logic [BLOCK_SIZE-1:0]                     lane_ready;
    logic [BLOCK_SIZE-1:0]                     alu_valid;
    commit_pkg::lane_commit_t [BLOCK_SIZE-1:0] alu_out;
    logic [BLOCK_SIZE-1:0]                     alu_ready;

    issue_dispatch #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready),
        .lane_valid  (lane_valid),
        .lane        (lane),
        .lane_ready  (lane_ready)
    );

    // One ALU per execute block
    for (genvar b = 0; b < BLOCK_SIZE; b++) begin : g_exec
        lane_alu alu (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (lane_valid[b]),
            .in        (lane[b]),
            .in_ready  (lane_ready[b]),
            .out_valid (alu_valid[b]),
            .out       (alu_out[b]),
            .out_ready (alu_ready[b])
        );
    end

    gather_unit #(
        .BLOCK_SIZE (BLOCK_SIZE),
        .ISSUE_CNT  (ISSUE_CNT)
    ) gather (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (alu_valid),
        .in           (alu_out),
        .in_ready     (alu_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

`default_nettype wire

/* verification/commit_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module commit_assertions #(
    parameter int ISSUE_CNT = 4
) (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                issue_valid,
    input commit_pkg::issue_req_t              issue,
    input logic                                issue_ready,
    input logic [ISSUE_CNT-1:0]                commit_valid,
    input commit_pkg::commit_t [ISSUE_CNT-1:0] commit,
    input logic [ISSUE_CNT-1:0]                commit_ready
);

    localparam int LANES = gpu_types_pkg::NUM_LANES;
    localparam int PIDS  = gpu_types_pkg::PID_CNT;

    commit_pkg::commit_t  exp_q [ISSUE_CNT][$];
    commit_pkg::commit_t  exp_head [ISSUE_CNT];
    logic [ISSUE_CNT-1:0] exp_avail;
    int                   outstanding;
    int                   fail_cnt = 0;

    // Reference result of one thread taken from the opcode definitions
    function automatic gpu_types_pkg::word_t op_result(
        input gpu_types_pkg::alu_op_t op,
        input gpu_types_pkg::word_t   x,
        input gpu_types_pkg::word_t   y
    );
        gpu_types_pkg::word_t r;
        r = '0;
        if (op == gpu_types_pkg::OP_ADD) begin
            r = x + y;
        end else if (op == gpu_types_pkg::OP_SUB) begin
            // Two's complement subtraction
            r = x + ~y + 1;
        end else if (op == gpu_types_pkg::OP_AND) begin
            r = x & y;
        end else if (op == gpu_types_pkg::OP_OR) begin
            r = x | y;
        end else if (op == gpu_types_pkg::OP_XOR) begin
            r = x ^ y;
        end else if (op == gpu_types_pkg::OP_SLL) begin
            // Each step of the 5-bit shift amount doubles the value
            r = x;
            for (int i = 0; i < int'(y[4:0]); i++) begin
                r = r + r;
            end
        end
        return r;
    endfunction

    // Packet p of a warp with only its own active threads filled in
    function automatic commit_pkg::commit_t expect_packet(
        input commit_pkg::issue_req_t req,
        input int                     p
    );
        commit_pkg::commit_t c;
        int                  t;
        c      = '0;
        c.uuid = req.uuid;
        c.wid  = req.wid;
        c.rd   = req.rd;
        c.wb   = req.wb;
        c.pid  = gpu_types_pkg::pid_t'(p);
        c.sop  = (p == 0);
        c.eop  = (p == PIDS - 1);
        for (int l = 0; l < LANES; l++) begin
            t          = p * LANES + l;
            c.tmask[t] = req.tmask[t];
            if (req.tmask[t]) begin
                c.data[t] = op_result(req.op, req.a[t], req.b[t]);
            end
        end
        return c;
    endfunction

    // Scoreboard with one in-order queue per issue slot
    always @(posedge clk or negedge rst_n) begin
        int total;
        if (!rst_n) begin
            for (int s = 0; s < ISSUE_CNT; s++) begin
                exp_q[s].delete();
            end
            exp_avail   <= '0;
            outstanding <= 0;
        end else begin
            for (int s = 0; s < ISSUE_CNT; s++) begin
                if (commit_valid[s] && commit_ready[s] && exp_q[s].size() > 0) begin
                    void'(exp_q[s].pop_front());
                end
            end
            if (issue_valid && issue_ready) begin
                for (int p = 0; p < PIDS; p++) begin
                    exp_q[int'(issue.wid) % ISSUE_CNT].push_back(expect_packet(issue, p));
                end
            end
            total = 0;
            for (int s = 0; s < ISSUE_CNT; s++) begin
                exp_avail[s] <= (exp_q[s].size() > 0);
                if (exp_q[s].size() > 0) begin
                    exp_head[s] <= exp_q[s][0];
                end
                total += exp_q[s].size();
            end
            outstanding <= total;
        end
    end

    for (genvar s = 0; s < ISSUE_CNT; s++) begin : g_slot
        a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
            commit_valid[s] |-> exp_avail[s])
        else begin
            $error("Commit on slot %0d while no packet was outstanding", s);
            fail_cnt++;
        end

        a_slot: assert property (@(posedge clk) disable iff (!rst_n)
            commit_valid[s] |-> (int'(commit[s].wid) % ISSUE_CNT == s))
        else begin
            $error("MISMATCH commit[%0d].wid: got %h, slot needs wid mod %0d == %h",
                s, $sampled(commit[s].wid), ISSUE_CNT, s);
            fail_cnt++;
        end

        a_header: assert property (@(posedge clk) disable iff (!rst_n)
            commit_valid[s] && exp_avail[s] |->
                {commit[s].uuid, commit[s].wid, commit[s].rd, commit[s].wb} ==
                {exp_head[s].uuid, exp_head[s].wid, exp_head[s].rd, exp_head[s].wb})
        else begin
            $error("MISMATCH commit[%0d].{uuid,wid,rd,wb}: got %h expected %h", s,
                $sampled({commit[s].uuid, commit[s].wid, commit[s].rd, commit[s].wb}),
                $sampled({exp_head[s].uuid, exp_head[s].wid, exp_head[s].rd,
                          exp_head[s].wb}));
            fail_cnt++;
        end

        a_order: assert property (@(posedge clk) disable iff (!rst_n)
            commit_valid[s] && exp_avail[s] |->
                {commit[s].pid, commit[s].sop, commit[s].eop} ==
                {exp_head[s].pid, exp_head[s].sop, exp_head[s].eop})
        else begin
            $error("MISMATCH commit[%0d].{pid,sop,eop}: got %h expected %h", s,
                $sampled({commit[s].pid, commit[s].sop, commit[s].eop}),
                $sampled({exp_head[s].pid, exp_head[s].sop, exp_head[s].eop}));
            fail_cnt++;
        end

        a_tmask: assert property (@(posedge clk) disable iff (!rst_n)
            commit_valid[s] && exp_avail[s] |-> commit[s].tmask == exp_head[s].tmask)
        else begin
            $error("MISMATCH commit[%0d].tmask: got %h expected %h", s,
                $sampled(commit[s].tmask), $sampled(exp_head[s].tmask));
            fail_cnt++;
        end

        a_data: assert property (@(posedge clk) disable iff (!rst_n)
            commit_valid[s] && exp_avail[s] |-> commit[s].data == exp_head[s].data)
        else begin
            $error("MISMATCH commit[%0d].data: got %h expected %h", s,
                $sampled(commit[s].data), $sampled(exp_head[s].data));
            fail_cnt++;
        end

        // A stalled commit has to wait unchanged
        a_stable: assert property (@(posedge clk) disable iff (!rst_n)
            commit_valid[s] && !commit_ready[s] |=> commit_valid[s] && $stable(commit[s]))
        else begin
            $error("Commit on slot %0d was dropped or changed while stalled", s);
            fail_cnt++;
        end
    end

endmodule

bind commit_top commit_assertions #(
    .ISSUE_CNT (ISSUE_CNT)
) checker_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .issue_ready  (issue_ready),
    .commit_valid (commit_valid),
    .commit       (commit),
    .commit_ready (commit_ready)
);

`default_nettype wire

/* verification/tb_commit_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_commit_top;

    localparam int ISSUE_CNT  = 4;
    localparam int WARPS      = 200;
    localparam int MAX_CYCLES = WARPS * gpu_types_pkg::PID_CNT * 4 + 100;

    logic                                clk;
    logic                                rst_n;
    logic                                issue_valid;
    commit_pkg::issue_req_t              issue;
    logic                                issue_ready;
    logic [ISSUE_CNT-1:0]                commit_valid;
    commit_pkg::commit_t [ISSUE_CNT-1:0] commit;
    logic [ISSUE_CNT-1:0]                commit_ready;

    logic [31:0]          rng;
    logic [31:0]          ready_rng;
    logic [ISSUE_CNT-1:0] stall_en;
    int                   cycles = 0;

    commit_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic build_issue(input int n);
        issue.uuid  = gpu_types_pkg::uuid_t'(n);
        issue.wid   = gpu_types_pkg::wid_t'(next_rand());
        issue.tmask = gpu_types_pkg::thread_mask_t'(next_rand());
        issue.op    = gpu_types_pkg::alu_op_t'(next_rand() % 6);
        issue.rd    = gpu_types_pkg::reg_t'(next_rand());
        issue.wb    = (next_rand() % 2) != 0;
        for (int t = 0; t < gpu_types_pkg::THREAD_CNT; t++) begin
            issue.a[t] = next_rand();
            issue.b[t] = next_rand();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Commit ports either always accept or stall about 30 percent of cycles
    initial begin
        commit_ready = '1;
        ready_rng    = xorshift(~32'd85284);
        stall_en     = ready_rng[ISSUE_CNT-1:0] | ISSUE_CNT'(1);
        forever begin
            @(posedge clk);
            #10;
            for (int p = 0; p < ISSUE_CNT; p++) begin
                ready_rng       = xorshift(ready_rng);
                commit_ready[p] = !stall_en[p] || (ready_rng % 100 >= 30);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $fatal(1, "Timeout");
        end
    end

    // End the run at the first failed assertion
    initial begin
        wait (uut.checker_inst.fail_cnt != 0);
        $display("Simulation finished: FAIL");
        $fatal(1, "Assertion failure reported by the commit checker");
    end

    initial begin
        rng         = 32'd85284;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        repeat (4) @(posedge clk);
        #10;
        rst_n = 1'b1;
        for (int n = 0; n < WARPS; n++) begin
            build_issue(n);
            issue_valid = 1'b1;
            do begin
                @(posedge clk);
            end while (!issue_ready);
            #10;
        end
        issue_valid = 1'b0;
        wait (uut.checker_inst.outstanding == 0);
        repeat (2) @(posedge clk);
        if (uut.checker_inst.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "Commit checker reported failures");
        end
    end

endmodule

`default_nettype wire

/* sources.f */
common/gpu_types_pkg.sv
common/commit_pkg.sv
execute/lane_splitter.sv
execute/lane_alu.sv
source/issue_dispatch.sv
gather/elastic_buffer.sv
gather/gather_unit.sv
source/commit_top.sv
verification/commit_assertions.sv
verification/tb_commit_top.sv
